//--- logic/mem_settings.svh
// address, data, id, burst length and block RAM width macros
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// physical address of the memory port
`define PADDR_WIDTH 32

// one data beat
`define MEM_DAT_WIDTH 64

// transaction id, echoed on b and r
`define MEM_TAG_WIDTH 4

`define LEN_WIDTH 8         // beats minus one

// byte address of the block RAM, 4 KB
`define BRAM_ADDR_WIDTH 12

`endif

//--- logic/nasti_pkg.sv
// NASTI bus types for responses, burst lengths, ids, strobes and data beats
`include "mem_settings.svh"

package nasti_pkg;

   typedef logic [1:0] resp_t;

   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;   // w_last misplaced
   localparam resp_t RESP_DECERR = 2'b11;   // outside the block RAM

   // burst length, beats minus one
   typedef logic [`LEN_WIDTH-1:0] len_t;

   typedef logic [`MEM_TAG_WIDTH-1:0] id_t;

   // one strobe bit per data byte
   typedef logic [`MEM_DAT_WIDTH/8-1:0] strb_t;

   typedef logic [`MEM_DAT_WIDTH-1:0] data_t;

endpackage

//--- logic/bram_pkg.sv
// block RAM line index type and the two-way decoded address union
`include "mem_settings.svh"

package bram_pkg;

   localparam int LINE_OFFSET = $clog2(`MEM_DAT_WIDTH / 8);    // byte within a line
   localparam int TAG_WIDTH   = `PADDR_WIDTH - `BRAM_ADDR_WIDTH;

   typedef logic [`BRAM_ADDR_WIDTH-LINE_OFFSET-1:0] line_t;

   // address as seen by the RAM
   typedef struct packed {
      logic [TAG_WIDTH-1:0]   upper;
      line_t                  line;
      logic [LINE_OFFSET-1:0] offset;
   } ram_view_t;

   // address as seen by the region split
   typedef struct packed {
      logic [TAG_WIDTH-1:0]        tag;     // nonzero means DRAM space
      logic [`BRAM_ADDR_WIDTH-1:0] offset;
   } region_view_t;

   typedef union packed {
      ram_view_t    ram;
      region_view_t region;
   } bram_addr_u;

endpackage

//--- logic/burst_fsm.sv
// write and read burst sequencing and all channel handshakes
`timescale 1ns/1ps
`include "mem_settings.svh"

module burst_fsm (
   input  logic              mig_clk,
   input  logic              reset,
   input  logic              aw_valid,
   output logic              aw_ready,
   input  nasti_pkg::id_t    aw_id,
   input  logic              w_valid,
   output logic              w_ready,
   input  logic              w_last,
   output logic              b_valid,
   input  logic              b_ready,
   output nasti_pkg::id_t    b_id,
   output nasti_pkg::resp_t  b_resp,
   input  logic              ar_valid,
   output logic              ar_ready,
   input  nasti_pkg::id_t    ar_id,
   output logic              r_valid,
   input  logic              r_ready,
   output nasti_pkg::id_t    r_id,
   output nasti_pkg::resp_t  r_resp,
   output logic              r_last,
   input  logic              last_beat,
   input  logic              in_region,
   output logic              start,
   output logic              step,
   output logic              is_write,
   output logic              ram_en,
   output logic              ram_we
);
   import nasti_pkg::*;

   localparam logic [2:0] S_IDLE   = 3'd0;
   localparam logic [2:0] S_WDATA  = 3'd1;
   localparam logic [2:0] S_WRESP  = 3'd2;
   localparam logic [2:0] S_RISSUE = 3'd3;   // RAM line presented
   localparam logic [2:0] S_RDATA  = 3'd4;

   logic [2:0] state, next_state;
   logic       wlast_err;
   logic       w_fire, r_fire;
   id_t        id_q;

   assign w_fire = (state == S_WDATA) && w_valid;
   assign r_fire = (state == S_RDATA) && r_ready;

   assign aw_ready = state == S_IDLE;
   assign ar_ready = (state == S_IDLE) && !aw_valid;   // write wins a tie
   assign start    = (state == S_IDLE) && (aw_valid || ar_valid);
   assign is_write = (state == S_IDLE) ? aw_valid : (state == S_WDATA || state == S_WRESP);

   assign w_ready = state == S_WDATA;
   assign step    = w_fire || r_fire;
   assign ram_en  = w_fire || (state == S_RISSUE);
   assign ram_we  = w_fire && in_region;   // DRAM space writes are dropped

   assign b_valid = state == S_WRESP;
   assign b_id    = id_q;
   assign b_resp  = !in_region ? RESP_DECERR : (wlast_err ? RESP_SLVERR : RESP_OKAY);

   assign r_valid = state == S_RDATA;
   assign r_id    = id_q;
   assign r_resp  = in_region ? RESP_OKAY : RESP_DECERR;
   assign r_last  = r_valid && last_beat;

   always_comb begin
      next_state = state;
      case (state)
         S_IDLE: begin
            if (aw_valid)
               next_state = S_WDATA;
            else if (ar_valid)
               next_state = S_RISSUE;
         end
         S_WDATA:  if (w_valid && last_beat) next_state = S_WRESP;
         S_WRESP:  if (b_ready) next_state = S_IDLE;
         S_RISSUE: next_state = S_RDATA;
         S_RDATA:  if (r_ready) next_state = last_beat ? S_IDLE : S_RISSUE;
         default:  next_state = S_IDLE;
      endcase
   end

   always_ff @(posedge mig_clk) begin
      if (reset) begin
         state     <= S_IDLE;
         wlast_err <= 1'b0;
      end else begin
         state <= next_state;
         if (start)
            wlast_err <= 1'b0;
         else if (w_fire && (w_last != last_beat))
            wlast_err <= 1'b1;   // sticky until the response
      end
   end

   always_ff @(posedge mig_clk) begin
      if (start)
         id_q <= aw_valid ? aw_id : ar_id;
   end

endmodule

//--- logic/beat_counter.sv
// beat index within a burst and last-beat flag
`timescale 1ns/1ps
`include "mem_settings.svh"

module beat_counter (
   input  logic            mig_clk,
   input  logic            reset,
   input  logic            start,
   input  logic            step,
   input  nasti_pkg::len_t len,
   output nasti_pkg::len_t beat,
   output logic            last_beat
);
   import nasti_pkg::*;

   len_t beat_q;
   len_t len_q;   // captured burst length

   always_ff @(posedge mig_clk) begin
      if (reset) begin
         beat_q <= '0;
         len_q  <= '0;
      end else if (start) begin
         beat_q <= '0;
         len_q  <= len;
      end else if (step) begin
         beat_q <= beat_q + len_t'(1);
      end
   end

   assign beat      = beat_q;
   assign last_beat = beat_q == len_q;

endmodule

//--- logic/beat_address.sv
// burst base register, region decode and per-beat line index
`timescale 1ns/1ps
`include "mem_settings.svh"

module beat_address (
   input  logic                    mig_clk,
   input  logic                    reset,
   input  logic                    start,
   input  logic [`PADDR_WIDTH-1:0] addr,
   input  nasti_pkg::len_t         beat,
   output bram_pkg::line_t         line,
   output logic                    in_region
);
   import bram_pkg::*;

   bram_addr_u base_q;

   always_ff @(posedge mig_clk) begin
      if (reset)
         base_q <= '0;
      else if (start)
         base_q <= addr;
   end

   // anything above the RAM window belongs to DRAM
   assign in_region = base_q.region.tag == '0;

   // incrementing burst that wraps at the end of the RAM
   assign line = base_q.ram.line + line_t'(beat);

endmodule

//--- logic/byte_lane_bram.sv
// inferred block RAM with per-byte write enables
`timescale 1ns/1ps
`include "mem_settings.svh"

module byte_lane_bram (
   input  logic              mig_clk,
   input  logic              en,
   input  logic              we,
   input  bram_pkg::line_t   line,
   input  nasti_pkg::strb_t  strb,
   input  nasti_pkg::data_t  wdata,
   output nasti_pkg::data_t  rdata
);
   import nasti_pkg::*;
   import bram_pkg::*;

   localparam int LINES = 2 ** $bits(line_t);

   data_t mem [0:LINES-1];
   line_t line_q;   // registered read line

   always_ff @(posedge mig_clk) begin
      if (en) begin
         line_q <= line;
         foreach (strb[i]) begin
            if (we && strb[i])
               mem[line][i*8 +: 8] <= wdata[i*8 +: 8];
         end
      end
   end

   assign rdata = mem[line_q];

endmodule

//--- logic/bram_port_top.sv
// burst memory port on block RAM with decode error for DRAM space
`timescale 1ns/1ps
`include "mem_settings.svh"

module bram_port_top (
   input  logic                    mig_clk,
   input  logic                    reset,
   input  logic                    aw_valid,
   output logic                    aw_ready,
   input  nasti_pkg::id_t          aw_id,
   input  logic [`PADDR_WIDTH-1:0] aw_addr,
   input  nasti_pkg::len_t         aw_len,
   input  logic                    w_valid,
   output logic                    w_ready,
   input  nasti_pkg::data_t        w_data,
   input  nasti_pkg::strb_t        w_strb,
   input  logic                    w_last,
   output logic                    b_valid,
   input  logic                    b_ready,
   output nasti_pkg::id_t          b_id,
   output nasti_pkg::resp_t        b_resp,
   input  logic                    ar_valid,
   output logic                    ar_ready,
   input  nasti_pkg::id_t          ar_id,
   input  logic [`PADDR_WIDTH-1:0] ar_addr,
   input  nasti_pkg::len_t         ar_len,
   output logic                    r_valid,
   input  logic                    r_ready,
   output nasti_pkg::id_t          r_id,
   output nasti_pkg::data_t        r_data,
   output nasti_pkg::resp_t        r_resp,
   output logic                    r_last
);
   import nasti_pkg::*;
   import bram_pkg::*;

   logic                    start, step, is_write;
   logic                    ram_en, ram_we;
   logic                    last_beat, in_region;
   logic [`PADDR_WIDTH-1:0] addr;
   len_t                    len, beat;
   line_t                   line;
   data_t                   ram_rdata;

   assign addr = is_write ? aw_addr : ar_addr;
   assign len  = is_write ? aw_len : ar_len;

   assign r_data = (r_resp == RESP_OKAY) ? ram_rdata : '0;   // zero outside the RAM

   burst_fsm u_burst_fsm (
      .mig_clk(mig_clk), .reset(reset),
      .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_id(aw_id),
      .w_valid(w_valid), .w_ready(w_ready), .w_last(w_last),
      .b_valid(b_valid), .b_ready(b_ready), .b_id(b_id), .b_resp(b_resp),
      .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_id(ar_id),
      .r_valid(r_valid), .r_ready(r_ready), .r_id(r_id), .r_resp(r_resp), .r_last(r_last),
      .last_beat(last_beat), .in_region(in_region),
      .start(start), .step(step), .is_write(is_write),
      .ram_en(ram_en), .ram_we(ram_we)
   );

   beat_counter u_beat_counter (
      .mig_clk(mig_clk), .reset(reset),
      .start(start), .step(step), .len(len),
      .beat(beat), .last_beat(last_beat)
   );

   beat_address u_beat_address (
      .mig_clk(mig_clk), .reset(reset),
      .start(start), .addr(addr), .beat(beat),
      .line(line), .in_region(in_region)
   );

   byte_lane_bram u_byte_lane_bram (
      .mig_clk(mig_clk),
      .en(ram_en), .we(ram_we), .line(line),
      .strb(w_strb), .wdata(w_data), .rdata(ram_rdata)
   );

endmodule

//--- verif/bram_port_checker.sv
// memory model and response compare for the burst memory port
`timescale 1ns/1ps
`include "mem_settings.svh"

module bram_port_checker (
   input  logic                    mig_clk,
   input  logic                    reset,
   input  logic                    aw_valid,
   input  logic                    aw_ready,
   input  nasti_pkg::id_t          aw_id,
   input  logic [`PADDR_WIDTH-1:0] aw_addr,
   input  logic                    w_valid,
   input  logic                    w_ready,
   input  nasti_pkg::data_t        w_data,
   input  nasti_pkg::strb_t        w_strb,
   input  logic                    b_valid,
   input  logic                    b_ready,
   input  nasti_pkg::id_t          b_id,
   input  nasti_pkg::resp_t        b_resp,
   input  logic                    ar_valid,
   input  logic                    ar_ready,
   input  nasti_pkg::id_t          ar_id,
   input  logic [`PADDR_WIDTH-1:0] ar_addr,
   input  nasti_pkg::len_t         ar_len,
   input  logic                    r_valid,
   input  logic                    r_ready,
   input  nasti_pkg::id_t          r_id,
   input  nasti_pkg::data_t        r_data,
   input  nasti_pkg::resp_t        r_resp,
   input  logic                    r_last,
   input  nasti_pkg::resp_t        exp_resp,
   output int                      value_errors,
   output int                      protocol_errors,
   output int                      open_items
);
   import nasti_pkg::*;

   localparam int LINE_W = `BRAM_ADDR_WIDTH - 3;
   localparam int BYTES = 2 ** `BRAM_ADDR_WIDTH;

   logic [7:0]        mem [0:BYTES-1];
   logic              known [0:BYTES-1];   // byte written by an okay burst
   logic [LINE_W-1:0] wq_line [$];
   strb_t             wq_strb [$];
   data_t             wq_data [$];

   int                write_open, w_beat, r_left;
   logic [LINE_W-1:0] w_line, r_line;
   id_t               w_id, r_idq;
   resp_t             w_exp, r_exp;

   assign open_items = write_open + r_left;

   task automatic compare_field(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      if (got !== exp) begin
         $display("error %s: got %h expected %h", name, got, exp);
         value_errors++;
      end
   endtask

   task automatic commit_writes();
      logic [`BRAM_ADDR_WIDTH-1:0] a;
      for (int q = 0; q < wq_line.size(); q++) begin
         for (int b = 0; b < 8; b++) begin
            a = {wq_line[q], 3'(b)};
            if (wq_strb[q][b]) begin
               mem[a]   = wq_data[q][b*8 +: 8];
               known[a] = 1'b1;
            end
         end
      end
   endtask

   task automatic check_read_beat();
      logic [`BRAM_ADDR_WIDTH-1:0] a;
      data_t exp_d, mask;
      exp_d = '0;
      mask  = '1;
      if (r_exp == RESP_OKAY) begin
         for (int b = 0; b < 8; b++) begin
            a = {r_line, 3'(b)};
            exp_d[b*8 +: 8] = known[a] ? mem[a] : 8'h00;
            mask[b*8 +: 8]  = known[a] ? 8'hff : 8'h00;
         end
      end
      compare_field("r_id", 64'(r_id), 64'(r_idq));
      compare_field("r_resp", 64'(r_resp), 64'(r_exp));
      compare_field("r_last", 64'(r_last), 64'(r_left == 1));
      compare_field("r_data", r_data & mask, exp_d);
   endtask

   initial begin
      value_errors    = 0;
      protocol_errors = 0;
      write_open      = 0;
      r_left          = 0;
      for (int i = 0; i < BYTES; i++)
         known[i] = 1'b0;
   end

   always @(posedge mig_clk) begin
      if (!reset) begin
         if (aw_valid && aw_ready) begin
            write_open = 1;
            w_beat     = 0;
            w_line     = aw_addr[`BRAM_ADDR_WIDTH-1:3];
            w_id       = aw_id;
            w_exp      = exp_resp;
         end
         if (w_ready) begin
            if (write_open == 0) begin
               $display("w_ready raised with no open write burst");
               protocol_errors++;
            end else if (w_valid) begin
               wq_line.push_back(w_line + LINE_W'(w_beat));   // wraps at RAM end
               wq_strb.push_back(w_strb);
               wq_data.push_back(w_data);
               w_beat++;
            end
         end
         if (b_valid && b_ready) begin
            if (write_open == 0) begin
               $display("write response arrived with no open write burst");
               protocol_errors++;
            end else begin
               compare_field("b_id", 64'(b_id), 64'(w_id));
               compare_field("b_resp", 64'(b_resp), 64'(w_exp));
               if (w_exp == RESP_OKAY)
                  commit_writes();
               write_open = 0;
            end
            wq_line.delete();
            wq_strb.delete();
            wq_data.delete();
         end
         if (ar_valid && ar_ready) begin
            r_left = int'(ar_len) + 1;
            r_line = ar_addr[`BRAM_ADDR_WIDTH-1:3];
            r_idq  = ar_id;
            r_exp  = exp_resp;
         end
         if (r_valid && r_ready) begin
            if (r_left == 0) begin
               $display("read beat arrived with no open read burst");
               protocol_errors++;
            end else begin
               check_read_beat();
               r_left--;
               r_line = r_line + LINE_W'(1);
            end
         end
      end
   end

endmodule

//--- verif/bram_port_tb.sv
// clock, reset, vector file stimulus, random back-pressure and timeout
`timescale 1ns/1ps
`include "mem_settings.svh"

module bram_port_tb;
   import nasti_pkg::*;

   localparam string VEC_FILE = "verif/bram_port_vectors.txt";
   localparam int    MAX_VEC  = 64;

   logic                    mig_clk, reset;
   logic                    aw_valid, aw_ready, w_valid, w_ready, w_last;
   logic                    b_valid, b_ready, ar_valid, ar_ready;
   logic                    r_valid, r_ready, r_last;
   id_t                     aw_id, b_id, ar_id, r_id;
   logic [`PADDR_WIDTH-1:0] aw_addr, ar_addr;
   len_t                    aw_len, ar_len;
   data_t                   w_data, r_data;
   strb_t                   w_strb;
   resp_t                   b_resp, r_resp, exp_resp;

   logic                    v_kind [MAX_VEC];
   id_t                     v_id [MAX_VEC];
   logic [31:0]             v_addr [MAX_VEC];
   len_t                    v_len [MAX_VEC];
   logic [31:0]             v_seed [MAX_VEC];
   strb_t                   v_strb [MAX_VEC];
   logic                    v_lerr [MAX_VEC];
   resp_t                   v_resp [MAX_VEC];

   integer seed;
   int     nvec, cycle, limit, file_errors;
   int     value_errors, protocol_errors, open_items;

   bram_port_top u_bram_port_top (.*);

   bram_port_checker u_checker (.*);

   always #10 mig_clk = ~mig_clk;

   // ready on three cycles out of four
   always @(posedge mig_clk) begin
      if (reset) begin
         b_ready <= 1'b0;
         r_ready <= 1'b0;
      end else begin
         b_ready <= ($random(seed) & 3) != 0;
         r_ready <= ($random(seed) & 3) != 0;
      end
   end

   always @(posedge mig_clk) begin
      cycle <= cycle + 1;
      if (cycle >= limit) begin
         $display("timeout after %0d cycles, the DUT stopped completing transactions", cycle);
         $display("TEST FAILED");
         $finish;
      end
   end

   function automatic data_t beat_data(input logic [31:0] s, input int n);
      logic [31:0] k;
      k = s + 32'(n) * 32'h0101;
      return {k, ~k ^ 32'(n)};
   endfunction

   task automatic read_vectors();
      int          fd, cnt;
      string       text;
      logic [31:0] f [8];
      fd = $fopen(VEC_FILE, "r");
      if (fd == 0) begin
         $display("cannot open the vector file %s", VEC_FILE);
         file_errors++;
         return;
      end
      while (!$feof(fd)) begin
         text = "";
         cnt = $fgets(text, fd);
         if (cnt > 1 && text.substr(0, 0) != "#") begin
            cnt = $sscanf(text, "%h %h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
            if (cnt == 8 && nvec < MAX_VEC) begin
               v_kind[nvec] = f[0][0];
               v_id[nvec]   = id_t'(f[1]);
               v_addr[nvec] = f[2];
               v_len[nvec]  = len_t'(f[3]);
               v_seed[nvec] = f[4];
               v_strb[nvec] = strb_t'(f[5]);
               v_lerr[nvec] = f[6][0];
               v_resp[nvec] = resp_t'(f[7]);
               nvec++;
            end
         end
      end
      $fclose(fd);
      if (nvec == 0) begin
         $display("the vector file holds no transactions");
         file_errors++;
      end
   endtask

   task automatic write_txn(input int i);
      @(posedge mig_clk);
      aw_valid <= 1'b1;
      aw_id    <= v_id[i];
      aw_addr  <= v_addr[i];
      aw_len   <= v_len[i];
      exp_resp <= v_resp[i];
      do @(posedge mig_clk); while (!aw_ready);
      aw_valid <= 1'b0;
      for (int n = 0; n <= int'(v_len[i]); n++) begin
         w_valid <= 1'b1;
         w_data  <= beat_data(v_seed[i], n);
         w_strb  <= v_strb[i];
         w_last  <= (n == int'(v_len[i])) && !v_lerr[i];   // error drops last
         do @(posedge mig_clk); while (!w_ready);
      end
      w_valid <= 1'b0;
      w_last  <= 1'b0;
      do @(posedge mig_clk); while (!(b_valid && b_ready));
   endtask

   task automatic read_txn(input int i);
      @(posedge mig_clk);
      ar_valid <= 1'b1;
      ar_id    <= v_id[i];
      ar_addr  <= v_addr[i];
      ar_len   <= v_len[i];
      exp_resp <= v_resp[i];
      do @(posedge mig_clk); while (!ar_ready);
      ar_valid <= 1'b0;
      do @(posedge mig_clk); while (!(r_valid && r_ready && r_last));
   endtask

   initial begin
      seed = 86646;
      mig_clk = 1'b0;
      reset = 1'b1;
      aw_valid = 1'b0;
      aw_id = '0;
      aw_addr = '0;
      aw_len = '0;
      w_valid = 1'b0;
      w_data = '0;
      w_strb = '0;
      w_last = 1'b0;
      b_ready = 1'b0;
      ar_valid = 1'b0;
      ar_id = '0;
      ar_addr = '0;
      ar_len = '0;
      r_ready = 1'b0;
      exp_resp = RESP_OKAY;
      nvec = 0;
      cycle = 0;
      file_errors = 0;
      read_vectors();
      limit = nvec * 40 + 100;
      repeat (16) @(posedge mig_clk);
      reset <= 1'b0;
      for (int i = 0; i < nvec; i++) begin
         if (v_kind[i])
            read_txn(i);
         else
            write_txn(i);
      end
      repeat (4) @(posedge mig_clk);
      $display("errors: %0d value, %0d protocol, %0d file, %0d transactions left open",
               value_errors, protocol_errors, file_errors, open_items);
      if (value_errors + protocol_errors + file_errors + open_items == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- verif/bram_port_vectors.txt
# kind (0 write, 1 read), id, address, len, data seed, strobe, w_last error, expected resp
# all columns hex; resp 0 okay, 2 slave error, 3 decode error
0 1 00000000 0 11110000 ff 0 0
1 2 00000000 0 00000000 00 0 0
0 3 00000008 0 22220000 ff 0 0
0 4 00000008 0 33330000 0f 0 0
1 5 00000008 0 00000000 00 0 0
0 6 00000100 3 44440000 ff 0 0
1 7 00000100 3 00000000 00 0 0
0 8 00000ff0 3 55550000 ff 0 0
1 9 00000ff0 3 00000000 00 0 0
1 a 00000000 1 00000000 00 0 0
0 b 00001000 1 66660000 ff 0 3
1 c 00001000 1 00000000 00 0 3
1 d 00000000 1 00000000 00 0 0
0 e 00000200 1 77770000 ff 1 2
0 f 00000300 7 88880000 ff 0 0
0 0 00000300 7 99990000 5a 0 0
1 1 00000300 7 00000000 00 0 0
1 2 00000100 0 00000000 00 0 0

//--- src.f
+incdir+logic
logic/nasti_pkg.sv
logic/bram_pkg.sv
logic/burst_fsm.sv
logic/beat_counter.sv
logic/beat_address.sv
logic/byte_lane_bram.sv
logic/bram_port_top.sv
verif/bram_port_checker.sv
verif/bram_port_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = bram_port_tb
FILELIST  = src.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir
